// File: n64_loader.f
verilog/n64_loader_pkg.sv
verilog/download_dispatch.sv
verilog/pifrom_loader.sv
verilog/cart_loader.sv
verilog/n64_loader.sv
test/n64_loader_sva.sv
test/n64_loader_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the n64_loader testbench with Verilator and run it.
# Exit status is 0 only when the testbench reports a pass.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module n64_loader_tb \
	-Mdir obj_dir \
	-f n64_loader.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

sim_output=$(./obj_dir/Vn64_loader_tb 2>&1)
sim_status=$?
echo "$sim_output"
if [ "$sim_status" -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_output" | grep -qx "Result: PASSED"; then
	exit 0
else
	echo "Pass message not found in simulation output"
	exit 1
fi

// File: test/n64_loader_stim.txt
// Download records, one half-word per line, all values in hex
// file index   byte address   half-word data
00 0000000 3780
00 0000002 4012
00 0000004 0f00
00 0000006 0000
00 00007fc a1b2
00 00007fe c3d4
01 0000000 8037
01 0000002 4012
01 0000004 0f00
01 0000006 0000
01 0123458 beef
01 012345a dead
01 3fffff0 5a5a
01 3fffff2 a5a5
05 0000000 1111
05 0000002 2222
02 0000004 3333
02 0000006 4444
40 0000804 5566
40 0000806 7788
40 0000010 99aa
40 0000012 bbcc

// File: test/n64_loader_tb.sv
`timescale 1ns/1ps

module n64_loader_tb;

	localparam int CART_START   = n64_loader_pkg::CART_START_DEFAULT;
	localparam int RESET_CYCLES = 5;
	// Strobe, worst SDRAM delay and host gap for one half-word
	localparam int MAX_REC_CYCLES = 16;
	localparam int MARGIN         = 100;

	logic clk_1x = 1'b0;
	logic reset;
	logic user_button;
	logic osd_reset;
	logic cart_ready;
	logic ioctl_wait;
	logic cart_loaded;
	logic core_reset;

	n64_loader_pkg::ioctl_t     ioctl;
	n64_loader_pkg::pifrom_wr_t pifrom;
	n64_loader_pkg::cart_wr_t   cart;

	// Records from the stimulus file
	n64_loader_pkg::file_index_t rec_index[$];
	n64_loader_pkg::ioctl_addr_t rec_addr[$];
	n64_loader_pkg::ioctl_data_t rec_data[$];

	// Expected writes, oldest first
	n64_loader_pkg::pifrom_wr_t pif_exp[$];
	n64_loader_pkg::cart_wr_t   cart_exp[$];
	n64_loader_pkg::pifrom_wr_t pif_next;
	n64_loader_pkg::cart_wr_t   cart_next;

	int error_count   = 0;
	int check_count   = 0;
	int test_count    = 0;
	int wren_count    = 0;
	int req_count     = 0;
	int cycle_count   = 0;
	int timeout_limit = 1000;

	logic [31:0] lfsr_state      = 32'hb9b2;
	logic        cart_seen       = 1'b0;
	logic        verdict_printed = 1'b0;

	n64_loader #(
		.CART_START (CART_START)
	) DUT (
		.clk_1x      (clk_1x),
		.reset       (reset),
		.user_button (user_button),
		.osd_reset   (osd_reset),
		.ioctl       (ioctl),
		.cart_ready  (cart_ready),
		.pifrom      (pifrom),
		.cart        (cart),
		.ioctl_wait  (ioctl_wait),
		.cart_loaded (cart_loaded),
		.core_reset  (core_reset)
	);

	always #50 clk_1x = ~clk_1x;

	always @(posedge clk_1x) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= timeout_limit) begin
			$display("Timeout, the run did not finish within %0d cycles", timeout_limit);
			verdict_printed = 1'b1;
			$display("Result: FAILED");
			$finish;
		end
	end

	// ====================
	// Helpers
	// ====================

	task automatic check_value(input string what, input logic [63:0] got,
			input logic [63:0] expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("[ERROR] %0d ns: %s is %0h, expected %0h", $time, what, got, expected);
		end
	endtask

	// Galois form with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h80200003;
		end
		return state >> 1;
	endfunction

	task automatic take_random_bits(input int nbits, output int value);
		int i;
		value = 0;
		for (i = 0; i < nbits; i++) begin
			value = (value << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	task automatic read_stim();
		int fd;
		int fields;
		string line;
		n64_loader_pkg::file_index_t index;
		n64_loader_pkg::ioctl_addr_t addr;
		n64_loader_pkg::ioctl_data_t data;
		fd = $fopen("test/n64_loader_stim.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file test/n64_loader_stim.txt");
			error_count++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.substr(0, 1) != "//") begin
				fields = $sscanf(line, "%h %h %h", index, addr, data);
				if (fields == 3) begin
					rec_index.push_back(index);
					rec_addr.push_back(addr);
					rec_data.push_back(data);
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic report_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			$display("test %0d, %s: passed", test_count, name);
		end else begin
			$display("test %0d, %s: failed with %0d errors", test_count, name,
				error_count - errors_before);
		end
	endtask

	// ====================
	// Output monitors
	// ====================

	always @(negedge clk_1x) begin
		if (!reset && pifrom.wren) begin
			wren_count++;
			if (pif_exp.size() == 0) begin
				$display("Unexpected boot ROM write at %0d ns", $time);
				error_count++;
			end else begin
				pif_next = pif_exp.pop_front();
				check_value("boot ROM address", 64'(pifrom.address), 64'(pif_next.address));
				check_value("boot ROM data", 64'(pifrom.data), 64'(pif_next.data));
			end
		end
	end

	always @(negedge clk_1x) begin
		if (!reset && cart.req) begin
			req_count++;
			if (cart_exp.size() == 0) begin
				$display("Unexpected SDRAM request at %0d ns", $time);
				error_count++;
			end else begin
				cart_next = cart_exp.pop_front();
				check_value("SDRAM address", 64'(cart.addr), 64'(cart_next.addr));
				check_value("SDRAM data", 64'(cart.data), 64'(cart_next.data));
			end
		end
	end

	// SDRAM answers each request after 1 to 8 cycles
	initial begin : sdram_model
		int ready_delay;
		n64_loader_pkg::cart_wr_t held;
		cart_ready = 1'b0;
		forever begin
			@(negedge clk_1x);
			if (!reset && cart.req) begin
				held = cart;
				check_value("wait with SDRAM request", 64'(ioctl_wait), 64'(1));
				take_random_bits(3, ready_delay);
				ready_delay = ready_delay + 1;
				repeat (ready_delay) @(posedge clk_1x);
				#1;
				check_value("wait before ready", 64'(ioctl_wait), 64'(1));
				check_value("SDRAM address held", 64'(cart.addr), 64'(held.addr));
				check_value("SDRAM data held", 64'(cart.data), 64'(held.data));
				cart_ready = 1'b1;
				@(posedge clk_1x);
				#1;
				check_value("wait after ready", 64'(ioctl_wait), 64'(0));
				cart_ready = 1'b0;
			end
		end
	end

	// ====================
	// Tests
	// ====================

	task automatic run_reset_test();
		int errors_before;
		errors_before = error_count;
		@(negedge clk_1x);
		@(negedge clk_1x);
		check_value("core_reset in reset", 64'(core_reset), 64'(1));
		check_value("wren in reset", 64'(pifrom.wren), 64'(0));
		check_value("req in reset", 64'(cart.req), 64'(0));
		check_value("wait in reset", 64'(ioctl_wait), 64'(0));
		check_value("cart_loaded in reset", 64'(cart_loaded), 64'(0));
		repeat (RESET_CYCLES - 2) @(posedge clk_1x);
		#1;
		reset = 1'b0;
		@(negedge clk_1x);
		check_value("core_reset after reset", 64'(core_reset), 64'(0));
		check_value("wait after reset", 64'(ioctl_wait), 64'(0));
		check_value("cart_loaded after reset", 64'(cart_loaded), 64'(0));
		report_test("reset", errors_before);
	endtask

	task automatic run_file(input int first, input int last);
		int errors_before;
		int wren_before;
		int req_before;
		int words;
		int r;
		logic is_pif;
		logic is_cart;
		n64_loader_pkg::file_index_t index;
		n64_loader_pkg::ioctl_addr_t first_addr;
		n64_loader_pkg::ioctl_data_t first_data;
		n64_loader_pkg::pifrom_wr_t  pif_want;
		n64_loader_pkg::cart_wr_t    cart_want;
		errors_before = error_count;
		wren_before = wren_count;
		req_before = req_count;
		words = 0;
		first_addr = '0;
		first_data = '0;
		index = rec_index[first];
		is_pif = (index[5:0] == n64_loader_pkg::PIF_INDEX);
		is_cart = (index[5:0] == n64_loader_pkg::CART_INDEX);

		@(posedge clk_1x);
		#1;
		ioctl.download = 1'b1;
		ioctl.index = index;
		// File select is registered on the next edge
		@(posedge clk_1x);
		#1;
		for (r = first; r < last; r++) begin
			if (!rec_addr[r][1]) begin
				first_addr = rec_addr[r];
				first_data = rec_data[r];
			end else begin
				words++;
				if (is_pif) begin
					pif_want.address = first_addr[10:2];
					pif_want.data = {first_data[7:0], first_data[15:8],
						rec_data[r][7:0], rec_data[r][15:8]};
					pif_want.wren = 1'b1;
					pif_exp.push_back(pif_want);
				end else if (is_cart) begin
					cart_want.addr = first_addr + n64_loader_pkg::ioctl_addr_t'(CART_START);
					cart_want.data = {rec_data[r], first_data};
					cart_want.req = 1'b1;
					cart_exp.push_back(cart_want);
				end
			end
			ioctl.addr = rec_addr[r];
			ioctl.dout = rec_data[r];
			ioctl.wr = 1'b1;
			@(posedge clk_1x);
			#1;
			ioctl.wr = 1'b0;
			// Host stalls while the SDRAM holds off
			while (ioctl_wait) begin
				@(posedge clk_1x);
				#1;
			end
		end

		@(negedge clk_1x);
		check_value("core_reset during download", 64'(core_reset), 64'(is_cart));
		@(posedge clk_1x);
		#1;
		ioctl.download = 1'b0;
		@(posedge clk_1x);
		@(negedge clk_1x);
		if (is_cart) begin
			cart_seen = 1'b1;
		end
		check_value("core_reset after download", 64'(core_reset), 64'(0));
		check_value("cart_loaded", 64'(cart_loaded), 64'(cart_seen));
		check_value("wait after download", 64'(ioctl_wait), 64'(0));
		check_value("boot ROM writes", 64'(wren_count - wren_before),
			64'(is_pif ? words : 0));
		check_value("SDRAM requests", 64'(req_count - req_before),
			64'(is_cart ? words : 0));
		check_value("pending boot ROM words", 64'(pif_exp.size()), 64'(0));
		check_value("pending SDRAM words", 64'(cart_exp.size()), 64'(0));
		report_test($sformatf("file index %02h", index), errors_before);
	endtask

	task automatic run_button_test();
		int errors_before;
		errors_before = error_count;
		@(posedge clk_1x);
		#1;
		osd_reset = 1'b1;
		@(negedge clk_1x);
		check_value("core_reset from osd_reset", 64'(core_reset), 64'(1));
		@(posedge clk_1x);
		#1;
		osd_reset = 1'b0;
		user_button = 1'b1;
		@(negedge clk_1x);
		check_value("core_reset from user_button", 64'(core_reset), 64'(1));
		@(posedge clk_1x);
		#1;
		user_button = 1'b0;
		@(negedge clk_1x);
		check_value("core_reset released", 64'(core_reset), 64'(0));
		check_value("cart_loaded sticky", 64'(cart_loaded), 64'(cart_seen));
		report_test("reset sources", errors_before);
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin : main
		int first;
		int last;
		reset = 1'b1;
		user_button = 1'b0;
		osd_reset = 1'b0;
		ioctl = '0;
		read_stim();
		timeout_limit = 2 * rec_index.size() * MAX_REC_CYCLES + MARGIN;
		if (rec_index.size() == 0) begin
			$display("No download records were read");
			error_count++;
		end
		run_reset_test();
		// Consecutive records with the same index form one file
		first = 0;
		while (first < rec_index.size()) begin
			last = first;
			while (last < rec_index.size() && rec_index[last] == rec_index[first]) begin
				last++;
			end
			run_file(first, last);
			first = last;
		end
		run_button_test();
		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
		verdict_printed = 1'b1;
		if (error_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// Run stopped before the verdict by a failing assertion
	final begin
		if (!verdict_printed) begin
			$display("Result: FAILED");
		end
	end

endmodule

// File: test/n64_loader_sva.sv
`timescale 1ns/1ps

module n64_loader_sva (
	input logic clk_1x,
	input logic reset,
	input logic wren,
	input logic req,
	input logic ioctl_wait,
	input logic cart_active
);

	// Boot ROM write lasts one cycle
	wren_single: assert property (@(posedge clk_1x) disable iff (reset) wren |=> !wren)
		else $error("boot ROM wren held longer than one cycle");

	// SDRAM request lasts one cycle
	req_single: assert property (@(posedge clk_1x) disable iff (reset) req |=> !req)
		else $error("SDRAM req held longer than one cycle");

	// Wait comes up together with the request it guards
	wait_with_req: assert property (@(posedge clk_1x) disable iff (reset)
		req |-> $rose(ioctl_wait))
		else $error("SDRAM request without wait rising");

	wait_idle: assert property (@(posedge clk_1x) disable iff (reset)
		!cart_active |-> !ioctl_wait)
		else $error("wait high while no cartridge file is active");

endmodule

// ====================
// Attach to the top level
// ====================

bind n64_loader n64_loader_sva u_sva (
	.clk_1x      (clk_1x),
	.reset       (reset),
	.wren        (pifrom.wren),
	.req         (cart.req),
	.ioctl_wait  (ioctl_wait),
	.cart_active (cart_active)
);

// File: verilog/n64_loader.sv
`timescale 1ns/1ps

module n64_loader #(
	parameter int CART_START = n64_loader_pkg::CART_START_DEFAULT
) (
	input  logic                       clk_1x,
	input  logic                       reset,
	input  logic                       user_button,
	input  logic                       osd_reset,
	// Host download bus
	input  n64_loader_pkg::ioctl_t     ioctl,
	// SDRAM answer to a cartridge write
	input  logic                       cart_ready,
	output n64_loader_pkg::pifrom_wr_t pifrom,
	output n64_loader_pkg::cart_wr_t   cart,
	// Back-pressure to the host
	output logic                       ioctl_wait,
	output logic                       cart_loaded,
	output logic                       core_reset
);

	logic pif_active;
	logic cart_active;

	// ====================
	// File dispatch
	// ====================

	download_dispatch u_dispatch (
		.clk_1x      (clk_1x),
		.reset       (reset),
		.user_button (user_button),
		.osd_reset   (osd_reset),
		.ioctl       (ioctl),
		.pif_active  (pif_active),
		.cart_active (cart_active),
		.cart_loaded (cart_loaded),
		.core_reset  (core_reset)
	);

	// ====================
	// Boot ROM path
	// ====================

	pifrom_loader u_pifrom (
		.clk_1x     (clk_1x),
		.reset      (reset),
		.pif_active (pif_active),
		.ioctl      (ioctl),
		.pifrom     (pifrom)
	);

	// ====================
	// Cartridge path
	// ====================

	// Cartridge image base in SDRAM
	cart_loader #(
		.CART_START (CART_START)
	) u_cart (
		.clk_1x      (clk_1x),
		.reset       (reset),
		.cart_active (cart_active),
		.ioctl       (ioctl),
		.cart_ready  (cart_ready),
		.cart        (cart),
		.ioctl_wait  (ioctl_wait)
	);

endmodule

// File: verilog/cart_loader.sv
`timescale 1ns/1ps

module cart_loader #(
	parameter int CART_START = n64_loader_pkg::CART_START_DEFAULT
) (
	input  logic                     clk_1x,
	input  logic                     reset,
	input  logic                     cart_active,
	input  n64_loader_pkg::ioctl_t   ioctl,
	input  logic                     cart_ready,
	output n64_loader_pkg::cart_wr_t cart,
	output logic                     ioctl_wait
);

	// SDRAM base of the cartridge image, truncated to the bus width
	localparam n64_loader_pkg::ioctl_addr_t CART_BASE =
		n64_loader_pkg::ioctl_addr_t'(CART_START);

	logic first_half;
	logic second_half;

	n64_loader_pkg::ioctl_addr_t wr_addr;
	n64_loader_pkg::ram_word_t   wr_data;
	logic                        req;
	logic                        wait_q;

	assign first_half  = cart_active && ioctl.wr && !ioctl.addr[1];
	assign second_half = cart_active && ioctl.wr && ioctl.addr[1];

	// ====================
	// Word assembly
	// ====================

	// Cartridge words keep host byte order with the second half on top
	always_ff @(posedge clk_1x) begin
		if (first_half) begin
			wr_data[15:0] <= ioctl.dout;
			wr_addr       <= ioctl.addr + CART_BASE;
		end

		if (second_half) begin
			wr_data[31:16] <= ioctl.dout;
		end
	end

	// ====================
	// Request and wait
	// ====================

	// One request per completed word
	always_ff @(posedge clk_1x) begin
		if (reset) begin
			req <= 1'b0;
		end else begin
			req <= second_half;
		end
	end

	// Host stalls from the request until the SDRAM takes the word.
	// Address and data stay put meanwhile, since no strobe can come in.
	always_ff @(posedge clk_1x) begin
		if (reset) begin
			wait_q <= 1'b0;
		end else if (!cart_active) begin
			// Download ended or another file is loading
			wait_q <= 1'b0;
		end else begin
			if (second_half) begin
				wait_q <= 1'b1;
			end
			// Ready wins because the word has been written
			if (cart_ready) begin
				wait_q <= 1'b0;
			end
		end
	end

	assign cart.addr  = wr_addr;
	assign cart.data  = wr_data;
	assign cart.req   = req;
	assign ioctl_wait = wait_q;

endmodule

// File: verilog/pifrom_loader.sv
`timescale 1ns/1ps

module pifrom_loader (
	input  logic                       clk_1x,
	input  logic                       reset,
	input  logic                       pif_active,
	input  n64_loader_pkg::ioctl_t     ioctl,
	output n64_loader_pkg::pifrom_wr_t pifrom
);

	// Boot ROM is big endian while the host sends little endian half-words
	function automatic logic [15:0] swap_half(input n64_loader_pkg::ioctl_data_t half);
		return {half[7:0], half[15:8]};
	endfunction

	logic first_half;
	logic second_half;

	n64_loader_pkg::pif_addr_t word_addr;
	n64_loader_pkg::ram_word_t word_data;
	logic                      wren;

	// Address bit 1 tells which half of the 32-bit word arrives
	assign first_half  = pif_active && ioctl.wr && !ioctl.addr[1];
	assign second_half = pif_active && ioctl.wr && ioctl.addr[1];

	// ====================
	// Word assembly
	// ====================

	always_ff @(posedge clk_1x) begin
		if (first_half) begin
			word_data[31:16] <= swap_half(ioctl.dout);
			// Byte address down to a word index inside the 2 kB ROM
			word_addr        <= ioctl.addr[10:2];
		end

		if (second_half) begin
			word_data[15:0] <= swap_half(ioctl.dout);
		end
	end

	// ====================
	// Write pulse
	// ====================

	// Single cycle pulse that lands together with the completed word
	always_ff @(posedge clk_1x) begin
		if (reset) begin
			wren <= 1'b0;
		end else begin
			wren <= second_half;
		end
	end

	assign pifrom.address = word_addr;
	assign pifrom.data    = word_data;
	assign pifrom.wren    = wren;

endmodule

// File: verilog/download_dispatch.sv
`timescale 1ns/1ps

module download_dispatch (
	input  logic                   clk_1x,
	input  logic                   reset,
	input  logic                   user_button,
	input  logic                   osd_reset,
	input  n64_loader_pkg::ioctl_t ioctl,
	output logic                   pif_active,
	output logic                   cart_active,
	output logic                   cart_loaded,
	output logic                   core_reset
);

	logic [5:0] file_sel;
	logic       pif_match;
	logic       cart_match;

	// Upper index bits carry host options and are ignored here
	assign file_sel = ioctl.index[5:0];

	assign pif_match  = ioctl.download && (file_sel == n64_loader_pkg::PIF_INDEX);
	assign cart_match = ioctl.download && (file_sel == n64_loader_pkg::CART_INDEX);

	// ====================
	// Active file select
	// ====================

	// One cycle behind download, so both drop together with it
	always_ff @(posedge clk_1x) begin
		if (reset) begin
			pif_active  <= 1'b0;
			cart_active <= 1'b0;
		end else begin
			pif_active  <= pif_match;
			cart_active <= cart_match;
		end
	end

	// ====================
	// Status and reset
	// ====================

	// Sticky once any cartridge data starts arriving
	always_ff @(posedge clk_1x) begin
		if (reset) begin
			cart_loaded <= 1'b0;
		end else if (cart_active) begin
			cart_loaded <= 1'b1;
		end
	end

	// Core stays in reset while the cartridge image is being replaced
	assign core_reset = reset
		| user_button
		| osd_reset
		| cart_active;

endmodule

// File: verilog/n64_loader_pkg.sv
package n64_loader_pkg;

	// ====================
	// Widths
	// ====================

	// Byte address of one download half-word
	typedef logic [26:0] ioctl_addr_t;
	typedef logic [15:0] ioctl_data_t;
	// Only the low six bits select a file
	typedef logic [7:0]  file_index_t;
	typedef logic [31:0] ram_word_t;
	// Word address into the 512-word boot ROM
	typedef logic [8:0]  pif_addr_t;

	// ====================
	// File indices
	// ====================

	localparam logic [5:0] PIF_INDEX  = 6'd0;
	localparam logic [5:0] CART_INDEX = 6'd1;

	// Cartridge image sits at 8 MB in SDRAM
	localparam int CART_START_DEFAULT = 8388608;

	// ====================
	// Bus structs
	// ====================

	// Host download bus, 53 bits
	typedef struct packed {
		logic        download;
		file_index_t index;
		ioctl_addr_t addr;
		ioctl_data_t dout;
		logic        wr;
	} ioctl_t;

	// Boot ROM write port, 42 bits
	typedef struct packed {
		pif_addr_t address;
		ram_word_t data;
		logic      wren;
	} pifrom_wr_t;

	// SDRAM write channel, 60 bits
	typedef struct packed {
		ioctl_addr_t addr;
		ram_word_t   data;
		logic        req;
	} cart_wr_t;

endpackage
